/* verilog.f */
+incdir+.
rob_pkg.sv
rob_dispatch_if.sv
rob_commit_if.sv
dispatch_stage.sv
rob_buffer.sv
commit_unit.sv
rob_top.sv
tb_rob.sv

/* Makefile */
# Verilator simulation of the reorder buffer subsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f verilog.f --top-module tb_rob -o sim_rob
	@out="$$(./obj_dir/sim_rob)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* tb_rob.sv */
/*
 Reorder buffer subsystem testbench
 Dispatches batches, writes them back in random order and checks the
 commit stream, allocation ids, back-pressure and exception flush
 */

`include "rob_config.svh"

module tb_rob;

   localparam int CLK_PERIOD = 20;
   localparam int NUM_TESTS  = 5;
   localparam logic [`DATA_W-1:0] RESULT_KEY = 32'h5a5a_c3c3;

   logic                clk;
   logic                reset;
   logic                in_valid;
   logic                in_ready;
   logic [`PC_W-1:0]    in_pc;
   logic [`PRF_AW-1:0]  in_prd;
   logic                in_prd_we;
   logic                alloc_valid;
   logic [`ROB_AW-1:0]  alloc_id;
   logic                wb_valid;
   logic [`ROB_AW-1:0]  wb_id;
   logic                wb_exc;
   logic [`DATA_W-1:0]  wb_result;
   logic                cmt_valid;
   logic                cmt_ready = 1'b0;
   logic [`PC_W-1:0]    cmt_pc;
   logic [`PRF_AW-1:0]  cmt_prd;
   logic                cmt_prd_we;
   logic [`DATA_W-1:0]  cmt_result;
   logic                cmt_exc;
   logic                flush;

   // Current batch, in dispatch order
   logic [`PC_W-1:0]    batch_pc  [16];
   logic [`PRF_AW-1:0]  batch_prd [16];
   logic                batch_we  [16];
   logic                batch_exc [16];

   rob_pkg::commit_t    exp_q[$];
   logic [`ROB_AW-1:0]  pend_id[$];
   int                  pend_idx[$];
   logic [`ROB_AW-1:0]  exp_id = '0;
   int                  alloc_cnt;
   int                  commit_cnt;
   int                  flush_cnt;
   int                  ready_mode = 0;
   int                  err_cnt = 0;
   int                  test_err0;
   int                  tests_run = 0;
   int                  tests_failed = 0;
   string               cur_test = "reset";
   logic                stalled = 1'b0;
   rob_pkg::commit_t    held;

   rob_top u_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_commit(input string name, input rob_pkg::commit_t exp,
                               input rob_pkg::commit_t act);
      if (exp !== act)
      begin
         err_cnt++;
         $display("Error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_id(input string name, input logic [`ROB_AW-1:0] exp,
                           input logic [`ROB_AW-1:0] act);
      if (exp !== act)
      begin
         err_cnt++;
         $display("Error %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         err_cnt++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // Expected commits follow dispatch order through the first exception
   function automatic int build_expected(input int n);
      rob_pkg::commit_t c;
      int cnt;
      logic stop;
      cnt = 0;
      stop = 1'b0;
      for (int i = 0; i < n; i++)
      begin
         if (!stop)
         begin
            c.pc     = batch_pc[i];
            c.prd    = batch_prd[i];
            c.prd_we = batch_we[i];
            c.result = batch_pc[i] ^ RESULT_KEY;
            c.exc    = batch_exc[i];
            exp_q.push_back(c);
            cnt++;
            stop = batch_exc[i];
         end
      end
      return cnt;
   endfunction

   // Allocation and commit monitor
   always @(posedge clk)
   begin
      rob_pkg::commit_t act;
      act = '{pc: cmt_pc, prd: cmt_prd, prd_we: cmt_prd_we, result: cmt_result, exc: cmt_exc};
      if (!reset)
      begin
         if (alloc_valid)
         begin
            check_id({cur_test, " alloc id"}, exp_id, alloc_id);
            pend_id.push_back(alloc_id);
            pend_idx.push_back(alloc_cnt);
            alloc_cnt++;
            exp_id = exp_id + 1'b1;
         end
         // Ids restart at 0 after a flush
         if (flush)
         begin
            exp_id = '0;
            flush_cnt++;
         end
         if (stalled)
         begin
            check_bit({cur_test, " held valid"}, 1'b1, cmt_valid);
            check_commit({cur_test, " held output"}, held, act);
         end
         if (cmt_valid && cmt_ready)
         begin
            if (exp_q.size() == 0)
            begin
               err_cnt++;
               $display("%s: unexpected commit of pc %h", cur_test, cmt_pc);
            end
            else
            begin
               check_commit({cur_test, " commit"}, exp_q.pop_front(), act);
            end
            commit_cnt++;
         end
         stalled = cmt_valid && !cmt_ready;
         held = act;
      end
   end

   // Commit ready is high in mode 0, random in mode 1 and held low otherwise
   always @(negedge clk)
   begin
      logic [31:0] r;
      r = $urandom;
      case (ready_mode)
         0:       cmt_ready = 1'b1;
         1:       cmt_ready = r[0];
         default: cmt_ready = 1'b0;
      endcase
   end

   task automatic dispatch_all(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         in_valid  = 1'b1;
         in_pc     = batch_pc[i];
         in_prd    = batch_prd[i];
         in_prd_we = batch_we[i];
         @(posedge clk);
         while (!in_ready)
            @(posedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   // Writes back allocated ids in shuffled groups as they appear
   task automatic writeback_all(input int n);
      logic [`ROB_AW-1:0] ids[$];
      int idx[$];
      logic [`ROB_AW-1:0] tid;
      int tix;
      int j;
      int done;
      logic [31:0] r;
      done = 0;
      @(negedge clk);
      while (done < n)
      begin
         if (pend_id.size() == 0)
         begin
            @(negedge clk);
         end
         else
         begin
            ids = pend_id;
            idx = pend_idx;
            pend_id.delete();
            pend_idx.delete();
            for (int k = ids.size() - 1; k > 0; k--)
            begin
               r = $urandom;
               j = r % (k + 1);
               tid = ids[j];
               ids[j] = ids[k];
               ids[k] = tid;
               tix = idx[j];
               idx[j] = idx[k];
               idx[k] = tix;
            end
            foreach (ids[k])
            begin
               wb_valid  = 1'b1;
               wb_id     = ids[k];
               wb_exc    = batch_exc[idx[k]];
               wb_result = batch_pc[idx[k]] ^ RESULT_KEY;
               done++;
               @(negedge clk);
            end
            wb_valid = 1'b0;
         end
      end
   endtask

   task automatic run_batch(input int n, input int exc_idx, input int mode);
      int exp_n;
      int exp_flush;
      logic [31:0] r;
      alloc_cnt  = 0;
      commit_cnt = 0;
      flush_cnt  = 0;
      exp_q.delete();
      for (int i = 0; i < n; i++)
      begin
         r = $urandom;
         batch_pc[i] = {r[31:2], 2'b00};
         r = $urandom;
         batch_prd[i] = r[5:0];
         batch_we[i]  = r[6];
         batch_exc[i] = (i == exc_idx);
      end
      exp_n = build_expected(n);
      exp_flush = (exc_idx >= 0 && exc_idx < n) ? 1 : 0;
      ready_mode = mode;
      if (mode == 2)
      begin
         dispatch_all(n);
         if (n > `ROB_DEPTH)
         begin
            @(posedge clk);
            check_bit({cur_test, " in_ready when full"}, 1'b0, in_ready);
         end
         writeback_all(n);
         ready_mode = 0;
      end
      else
      begin
         fork
            dispatch_all(n);
            writeback_all(n);
         join
      end
      while (commit_cnt < exp_n)
         @(posedge clk);
      // Idle time to catch stray commits
      repeat (10) @(posedge clk);
      if (flush_cnt != exp_flush)
      begin
         err_cnt++;
         $display("Error %s flush pulses: expected %0d, actual %0d", cur_test,
                  exp_flush, flush_cnt);
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_err0 = err_cnt;
   endtask

   task automatic end_test();
      tests_run++;
      if (err_cnt == test_err0)
      begin
         $display("Test %-16s passed", cur_test);
      end
      else
      begin
         tests_failed++;
         $display("Test %-16s failed with %0d errors", cur_test, err_cnt - test_err0);
      end
   endtask

   initial
   begin
      #(NUM_TESTS * 400 * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      int exc_idx;
      void'($urandom(66));
      clk       = 1'b0;
      reset     = 1'b1;
      in_valid  = 1'b0;
      in_pc     = '0;
      in_prd    = '0;
      in_prd_we = 1'b0;
      wb_valid  = 1'b0;
      wb_id     = '0;
      wb_exc    = 1'b0;
      wb_result = '0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      start_test("reset_and_order");
      @(posedge clk);
      check_bit("in_ready after reset", 1'b1, in_ready);
      check_bit("alloc_valid after reset", 1'b0, alloc_valid);
      check_bit("cmt_valid after reset", 1'b0, cmt_valid);
      check_bit("flush after reset", 1'b0, flush);
      run_batch(8, -1, 0);
      end_test();

      // Ten allocations wrap the id past the depth
      start_test("alloc_wrap");
      run_batch(10, -1, 0);
      end_test();

      start_test("backpressure");
      run_batch(`ROB_DEPTH + 1, -1, 2);
      end_test();

      start_test("random_ready");
      run_batch(12, -1, 1);
      end_test();

      // Short batch leaves the tail away from 0 unless the flush clears it
      start_test("exception_flush");
      exc_idx = 1 + int'($urandom % 4);
      run_batch(6, exc_idx, 2);
      run_batch(3, -1, 0);
      end_test();

      $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
               tests_run - tests_failed, tests_failed, err_cnt);
      if (err_cnt == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* rob_top.sv */
/*
 Reorder buffer subsystem top
 Joins the dispatch stage, the buffer and the commit unit behind plain ports
 */

`include "rob_config.svh"

module rob_top
(
   input  logic                clk,
   input  logic                reset,
   // Dispatch input
   input  logic                in_valid,
   output logic                in_ready,
   input  logic [`PC_W-1:0]    in_pc,
   input  logic [`PRF_AW-1:0]  in_prd,
   input  logic                in_prd_we,
   // Allocation
   output logic                alloc_valid,
   output logic [`ROB_AW-1:0]  alloc_id,
   // Writeback
   input  logic                wb_valid,
   input  logic [`ROB_AW-1:0]  wb_id,
   input  logic                wb_exc,
   input  logic [`DATA_W-1:0]  wb_result,
   // Commit
   output logic                cmt_valid,
   input  logic                cmt_ready,
   output logic [`PC_W-1:0]    cmt_pc,
   output logic [`PRF_AW-1:0]  cmt_prd,
   output logic                cmt_prd_we,
   output logic [`DATA_W-1:0]  cmt_result,
   output logic                cmt_exc,
   output logic                flush
);

   rob_dispatch_if u_disp_if ();
   rob_commit_if   u_cmt_if ();

   dispatch_stage u_dispatch (
      .clk       (clk),
      .reset     (reset),
      .flush     (flush),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_pc     (in_pc),
      .in_prd    (in_prd),
      .in_prd_we (in_prd_we),
      .disp      (u_disp_if.producer)
   );

   rob_buffer u_buffer (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .disp        (u_disp_if.buffer),
      .alloc_valid (alloc_valid),
      .alloc_id    (alloc_id),
      .wb_valid    (wb_valid),
      .wb_id       (wb_id),
      .wb_exc      (wb_exc),
      .wb_result   (wb_result),
      .cmt         (u_cmt_if.buffer)
   );

   commit_unit u_commit (
      .clk        (clk),
      .reset      (reset),
      .cmt        (u_cmt_if.consumer),
      .cmt_valid  (cmt_valid),
      .cmt_ready  (cmt_ready),
      .cmt_pc     (cmt_pc),
      .cmt_prd    (cmt_prd),
      .cmt_prd_we (cmt_prd_we),
      .cmt_result (cmt_result),
      .cmt_exc    (cmt_exc),
      .flush      (flush)
   );

endmodule

/* commit_unit.sv */
/*
 Commit unit
 Retires the buffer head in order through an output register and pulses
 flush when the retired instruction raised an exception
 */

`include "rob_config.svh"

module commit_unit
(
   input  logic                clk,
   input  logic                reset,
   rob_commit_if.consumer      cmt,
   output logic                cmt_valid,
   input  logic                cmt_ready,
   output logic [`PC_W-1:0]    cmt_pc,
   output logic [`PRF_AW-1:0]  cmt_prd,
   output logic                cmt_prd_we,
   output logic [`DATA_W-1:0]  cmt_result,
   output logic                cmt_exc,
   output logic                flush
);

   logic              valid_q;
   logic              flush_q;
   rob_pkg::commit_t  data_q;
   logic              pop;

   // Hold off popping while a flush is in progress
   assign cmt.ready = (~valid_q | cmt_ready) & ~flush_q;
   assign pop       = cmt.valid & cmt.ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_q <= 1'b0;
         flush_q <= 1'b0;
      end
      else
      begin
         flush_q <= pop & cmt.head.exc;
         if (pop)
         begin
            valid_q <= 1'b1;
         end
         else if (cmt_ready)
         begin
            valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (pop)
      begin
         data_q <= cmt.head;
      end
   end

   assign cmt_valid  = valid_q;
   assign cmt_pc     = data_q.pc;
   assign cmt_prd    = data_q.prd;
   assign cmt_prd_we = data_q.prd_we;
   assign cmt_result = data_q.result;
   assign cmt_exc    = data_q.exc;
   assign flush      = flush_q;

endmodule

/* rob_buffer.sv */
/*
 Reorder buffer
 Circular store allocated in order, with done and exception tags set by
 out of order writeback and the head presented to the commit unit
 */

`include "rob_config.svh"

module rob_buffer
(
   input  logic                clk,
   input  logic                reset,
   input  logic                flush,
   rob_dispatch_if.buffer      disp,
   output logic                alloc_valid,
   output logic [`ROB_AW-1:0]  alloc_id,
   input  logic                wb_valid,
   input  logic [`ROB_AW-1:0]  wb_id,
   input  logic                wb_exc,
   input  logic [`DATA_W-1:0]  wb_result,
   rob_commit_if.buffer        cmt
);

   logic [`ROB_AW-1:0]    head_q;
   logic [`ROB_AW-1:0]    tail_q;
   logic [`ROB_AW:0]      count_q;
   logic [`ROB_DEPTH-1:0] done_q;
   logic [`ROB_DEPTH-1:0] exc_q;

   rob_pkg::entry_t       entry_mem  [`ROB_DEPTH];
   logic [`DATA_W-1:0]    result_mem [`ROB_DEPTH];

   rob_pkg::wb_t          wb;
   rob_pkg::entry_t       head_entry;
   logic                  full;
   logic                  empty;
   logic                  push;
   logic                  pop;

   assign wb = '{rob_id: wb_id, exc: wb_exc, result: wb_result};

   // Depth is a power of two, so the count MSB marks full
   assign full  = count_q[`ROB_AW];
   assign empty = (count_q == '0);

   // No allocation in the flush cycle
   assign disp.ready = ~full & ~flush;
   assign push       = disp.valid & disp.ready;
   assign pop        = cmt.valid & cmt.ready;

   assign alloc_valid = push;
   assign alloc_id    = tail_q;

   // Pointers and occupancy
   always_ff @(posedge clk)
   begin
      if (reset | flush)
      begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end
      else
      begin
         if (push)
         begin
            tail_q <= tail_q + 1'b1;
         end
         if (pop)
         begin
            head_q <= head_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Tags clear on allocation and set on writeback
   always_ff @(posedge clk)
   begin
      if (reset | flush)
      begin
         done_q <= '0;
      end
      else
      begin
         if (push)
         begin
            done_q[tail_q] <= 1'b0;
            exc_q[tail_q]  <= 1'b0;
         end
         if (wb_valid)
         begin
            done_q[wb.rob_id] <= 1'b1;
            exc_q[wb.rob_id]  <= wb.exc;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         entry_mem[tail_q] <= disp.entry;
      end
      if (wb_valid)
      begin
         result_mem[wb.rob_id] <= wb.result;
      end
   end

   // Head record
   assign head_entry = entry_mem[head_q];
   assign cmt.valid  = ~empty & done_q[head_q];
   assign cmt.head   = '{pc:     head_entry.pc,
                         prd:    head_entry.prd,
                         prd_we: head_entry.prd_we,
                         result: result_mem[head_q],
                         exc:    exc_q[head_q]};

endmodule

/* dispatch_stage.sv */
/*
 Dispatch stage
 Registers one decoded instruction and offers it to the reorder buffer,
 decoupling the decoder from the buffer full condition
 */

`include "rob_config.svh"

module dispatch_stage
(
   input  logic                clk,
   input  logic                reset,
   input  logic                flush,
   input  logic                in_valid,
   output logic                in_ready,
   input  logic [`PC_W-1:0]    in_pc,
   input  logic [`PRF_AW-1:0]  in_prd,
   input  logic                in_prd_we,
   rob_dispatch_if.producer    disp
);

   logic             valid_q;
   rob_pkg::entry_t  entry_q;
   logic             accept;
   logic             xfer;

   assign xfer = disp.valid & disp.ready;

   // Room when empty or draining on this edge, never while flushing
   assign in_ready = (~valid_q | disp.ready) & ~flush;
   assign accept   = in_valid & in_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_q <= 1'b0;
      end
      else if (flush)
      begin
         valid_q <= 1'b0;
      end
      else if (accept)
      begin
         valid_q <= 1'b1;
      end
      else if (xfer)
      begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         entry_q <= '{pc: in_pc, prd: in_prd, prd_we: in_prd_we};
      end
   end

   assign disp.valid = valid_q;
   assign disp.entry = entry_q;

endmodule

/* rob_commit_if.sv */
/*
 Commit interface
 Valid/ready path carrying the head entry from the buffer to the commit unit
 */

interface rob_commit_if;

   logic              valid;
   logic              ready;
   rob_pkg::commit_t  head;

   modport buffer (
      output valid,
      output head,
      input  ready
   );

   modport consumer (
      input  valid,
      input  head,
      output ready
   );

endinterface

/* rob_dispatch_if.sv */
/*
 Dispatch interface
 Valid/ready allocation path from the dispatch stage into the buffer
 */

interface rob_dispatch_if;

   logic             valid;
   logic             ready;
   rob_pkg::entry_t  entry;

   modport producer (
      output valid,
      output entry,
      input  ready
   );

   modport buffer (
      input  valid,
      input  entry,
      output ready
   );

endinterface

/* rob_pkg.sv */
/*
 Reorder buffer types
 Entry written at allocation, writeback payload and the record presented at commit
 */

`include "rob_config.svh"

package rob_pkg;

   // Written at allocation
   typedef struct packed {
      logic [`PC_W-1:0]   pc;
      logic [`PRF_AW-1:0] prd;
      logic               prd_we;
   } entry_t;

   // Out of order writeback payload
   typedef struct packed {
      logic [`ROB_AW-1:0] rob_id;
      logic               exc;
      logic [`DATA_W-1:0] result;
   } wb_t;

   // Head record seen by the commit unit
   typedef struct packed {
      logic [`PC_W-1:0]   pc;
      logic [`PRF_AW-1:0] prd;
      logic               prd_we;
      logic [`DATA_W-1:0] result;
      logic               exc;
   } commit_t;

endpackage

/* rob_config.svh */
/*
 Reorder buffer configuration
 Depth, index and datapath widths shared by the package and the RTL
 */

`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Index width of the buffer
`define ROB_AW 3
`define ROB_DEPTH (1 << `ROB_AW)

`define PC_W 32
`define DATA_W 32
`define PRF_AW 6

`endif
